// File: Bender.yml
package:
  name: rv32i_instruction_decode

sources:
  - hdl/rv_decode_pkg.sv
  - hdl/opcode_classify.sv
  - hdl/field_check.sv
  - hdl/imm_gen.sv
  - hdl/microcode_gen.sv
  - hdl/decode_ctrl.sv
  - hdl/instruction_decode.sv
  - target: test
    files:
      - tb/tb_instruction_decode.sv

// File: hdl/decode_ctrl.sv
// Request FSM (idle, decode, done) and result registers
`timescale 1ns/1ns

module decode_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          available,
    input  rv_decode_pkg::decode_result_t next_result,
    output rv_decode_pkg::decode_result_t result,
    output logic                          busy,
    output logic                          fault
);
    import rv_decode_pkg::*;

    decode_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            busy  <= 1'b0;
            fault <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (available) begin
                        state <= DECODE;
                        busy  <= 1'b1;
                    end else begin
                        busy  <= 1'b0;
                        fault <= 1'b0;
                    end
                end
                DECODE: begin
                    fault <= next_result.fault;
                    busy  <= 1'b0;
                    state <= DONE;
                end
                DONE: begin
                    if (!available) begin
                        state <= IDLE;  // Requester released
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            result <= next_result;  // Held until next request
        end
    end

endmodule

// File: hdl/field_check.sv
// Encoding checks per opcode class
// Opcode, register index, funct3 and funct7 error flags
`timescale 1ns/1ns

module field_check (
    input  rv_decode_pkg::instr_fields_t fields,
    input  rv_decode_pkg::opcode_class_t cls,
    output rv_decode_pkg::instr_errors_t errors
);

    logic rs1_read;
    logic rs2_read;
    logic rd_write;
    logic f3_bad;
    logic op_f7_bad;
    logic opimm_f7_bad;

    assign rs1_read = ~(cls.lui | cls.auipc | cls.jal);
    assign rs2_read = cls.op | cls.store | cls.branch;
    assign rd_write = ~(cls.store | cls.branch);

    assign errors.bad_opcode = ~|cls;

    // Upper index bit set means outside the 16-register file
    assign errors.bad_rs = (rs1_read & fields.rs1[4]) | (rs2_read & fields.rs2[4]);
    assign errors.bad_rd = rd_write & fields.rd[4];

    always_comb begin
        f3_bad = 1'b0;
        if (cls.store && fields.funct3 >= 3'd3) begin
            f3_bad = 1'b1;
        end
        if (cls.load && (fields.funct3 == 3'd3 || fields.funct3 >= 3'd6)) begin
            f3_bad = 1'b1;
        end
        if (cls.jalr && fields.funct3 != 3'd0) begin
            f3_bad = 1'b1;
        end
        if (cls.branch && (fields.funct3 == 3'd2 || fields.funct3 == 3'd3)) begin
            f3_bad = 1'b1;
        end
    end

    assign errors.bad_funct3 = f3_bad;

    // Only ADD/SUB and SRL/SRA take the alternate encoding
    assign op_f7_bad = (fields.funct7 != 7'd0 && fields.funct7 != 7'd32) ||
                       (fields.funct7 == 7'd32 && fields.funct3 != 3'd0 &&
                        fields.funct3 != 3'd5);

    // Shift immediates carry funct7 in the upper immediate bits
    assign opimm_f7_bad = (fields.funct3 == 3'd1 && fields.funct7 != 7'd0) ||
                          (fields.funct3 == 3'd5 && fields.funct7 != 7'd0 &&
                           fields.funct7 != 7'd32);

    assign errors.bad_funct7 = (cls.op & op_f7_bad) | (cls.opimm & opimm_f7_bad);

endmodule

// File: hdl/imm_gen.sv
// Immediate generation for U, J, B, S and I formats
`timescale 1ns/1ns

module imm_gen (
    input  rv_decode_pkg::instr_fields_t fields,
    input  rv_decode_pkg::opcode_class_t cls,
    output rv_decode_pkg::word_t         imm
);

    logic sign;

    assign sign = fields.funct7[6];  // Instruction bit 31

    always_comb begin
        if (cls.lui || cls.auipc) begin
            imm = {fields.funct7, fields.rs2, fields.rs1, fields.funct3, 12'b0};
        end else if (cls.jal) begin
            imm = {{12{sign}}, fields.rs1, fields.funct3, fields.rs2[0],
                   fields.funct7[5:0], fields.rs2[4:1], 1'b0};
        end else if (cls.branch) begin
            imm = {{20{sign}}, fields.rd[0], fields.funct7[5:0], fields.rd[4:1], 1'b0};
        end else if (cls.store) begin
            imm = {{20{sign}}, fields.funct7, fields.rd};
        end else begin
            // I-format, also used by invalid opcodes
            imm = {{20{sign}}, fields.funct7, fields.rs2};
        end
    end

endmodule

// File: hdl/instruction_decode.sv
// RV32I decoder top level for the 16-register subset
// Classify, check, immediate and microcode stages feed the
// request FSM and result registers
`timescale 1ns/1ns

module instruction_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          available,
    input  rv_decode_pkg::word_t          instr,
    output rv_decode_pkg::decode_result_t result,
    output logic                          busy,
    output logic                          fault
);
    import rv_decode_pkg::*;

    instr_fields_t  fields;
    opcode_class_t  cls;
    instr_errors_t  errors;
    word_t          imm;
    decode_result_t next_result;

    opcode_classify u_classify (
        .instr  (instr),
        .fields (fields),
        .cls    (cls)
    );

    field_check u_check (
        .fields (fields),
        .cls    (cls),
        .errors (errors)
    );

    imm_gen u_imm (
        .fields (fields),
        .cls    (cls),
        .imm    (imm)
    );

    microcode_gen u_ucode (
        .fields      (fields),
        .cls         (cls),
        .errors      (errors),
        .imm         (imm),
        .next_result (next_result)
    );

    decode_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .available   (available),
        .next_result (next_result),
        .result      (result),
        .busy        (busy),
        .fault       (fault)
    );

endmodule

// File: hdl/microcode_gen.sv
// Stage microcode, mux selects and fault flag
// Error flags gate every stage enable here
`timescale 1ns/1ns

module microcode_gen (
    input  rv_decode_pkg::instr_fields_t  fields,
    input  rv_decode_pkg::opcode_class_t  cls,
    input  rv_decode_pkg::instr_errors_t  errors,
    input  rv_decode_pkg::word_t          imm,
    output rv_decode_pkg::decode_result_t next_result
);

    logic fault;
    logic rs1_read;
    logic rd_write;
    logic alu_used;
    logic alt_ok;

    assign fault    = |errors;
    assign rs1_read = ~(cls.lui | cls.auipc | cls.jal);
    assign rd_write = ~(cls.store | cls.branch);
    assign alu_used = cls.op | cls.opimm | cls.branch | cls.load | cls.store |
                      cls.auipc | cls.jalr;

    // SUB and SRA for OP, SRAI for OP-IMM
    assign alt_ok = (cls.op & (fields.funct3 == 3'd0 || fields.funct3 == 3'd5)) |
                    (cls.opimm & (fields.funct3 == 3'd5));

    assign next_result.imm   = imm;
    assign next_result.fault = fault;

    assign next_result.rd_rf.en  = ~fault & rs1_read;
    assign next_result.rd_rf.rs1 = fields.rs1[3:0];
    assign next_result.rd_rf.rs2 = fields.rs2[3:0];

    assign next_result.ex_alu.en     = ~fault & alu_used;
    assign next_result.ex_alu.branch = cls.branch;
    assign next_result.ex_alu.alt    = fields.funct7[5] & alt_ok;
    assign next_result.ex_alu.op     = (cls.op | cls.opimm | cls.branch) ? fields.funct3 : 3'b0;

    assign next_result.ma_mem.en    = ~fault & (cls.load | cls.store);
    assign next_result.ma_mem.store = cls.store;
    assign next_result.ma_mem.width = fields.funct3;

    assign next_result.wb_rf.en        = ~fault & rd_write;
    assign next_result.wb_rf.rf_target = 1'b1;
    assign next_result.wb_rf.rd        = fields.rd[3:0];
    assign next_result.wb_rf.rsvd      = 4'b0;

    assign next_result.sel.alu_a = cls.auipc;
    assign next_result.sel.alu_b = ~(cls.branch | cls.op);
    assign next_result.sel.wb    = {cls.load | cls.jal | cls.jalr,
                                    cls.lui | cls.jal | cls.jalr};
    assign next_result.sel.npc   = {cls.branch | cls.jal,
                                    cls.jalr | cls.branch};

endmodule

// File: hdl/opcode_classify.sv
// Instruction field split and opcode classification
// One class flag per supported opcode and none for any other
`timescale 1ns/1ns

module opcode_classify (
    input  rv_decode_pkg::word_t         instr,
    output rv_decode_pkg::instr_fields_t fields,
    output rv_decode_pkg::opcode_class_t cls
);
    import rv_decode_pkg::*;

    assign fields.funct7 = instr[31:25];
    assign fields.rs2    = instr[24:20];
    assign fields.rs1    = instr[19:15];
    assign fields.funct3 = instr[14:12];
    assign fields.rd     = instr[11:7];
    assign fields.opcode = instr[6:0];

    // Exact match on all seven bits
    always_comb begin
        cls = '0;
        case (instr[6:0])
            OPC_OP:     cls.op     = 1'b1;
            OPC_OPIMM:  cls.opimm  = 1'b1;
            OPC_LOAD:   cls.load   = 1'b1;
            OPC_STORE:  cls.store  = 1'b1;
            OPC_AUIPC:  cls.auipc  = 1'b1;
            OPC_BRANCH: cls.branch = 1'b1;
            OPC_JAL:    cls.jal    = 1'b1;
            OPC_JALR:   cls.jalr   = 1'b1;
            OPC_LUI:    cls.lui    = 1'b1;
            default: begin
                cls = '0;  // FENCE, SYSTEM and the rest
            end
        endcase
    end

endmodule

// File: hdl/rv_decode_pkg.sv
// Shared types for the RV32I decoder
//   instruction fields, opcode class and error flags
//   per-stage microcode structs and mux selects
//   registered decode result, FSM states, opcode constants
package rv_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;  // Architectural index as encoded
    typedef logic [3:0]  rf_addr_t;  // 16-register subset

    // Field order follows the instruction word from the msb down
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    typedef struct packed {
        logic op;
        logic opimm;
        logic load;
        logic store;
        logic auipc;
        logic branch;
        logic jal;
        logic jalr;
        logic lui;
    } opcode_class_t;

    typedef struct packed {
        logic bad_opcode;
        logic bad_rs;
        logic bad_rd;
        logic bad_funct3;
        logic bad_funct7;
    } instr_errors_t;

    typedef struct packed {
        logic     en;
        rf_addr_t rs1;
        rf_addr_t rs2;
    } rd_rf_uop_t;

    typedef struct packed {
        logic       en;
        logic       branch;  // Compare result drives the pc
        logic       alt;     // SUB / SRA / SRAI
        logic [2:0] op;
    } ex_alu_uop_t;

    typedef struct packed {
        logic       en;
        logic       store;
        logic [2:0] width;   // funct3 width and sign code
    } ma_mem_uop_t;

    typedef struct packed {
        logic       en;
        logic       rf_target;
        rf_addr_t   rd;
        logic [3:0] rsvd;
    } wb_rf_uop_t;

    typedef struct packed {
        logic       alu_a;   // 0 rs1, 1 pc
        logic       alu_b;   // 0 rs2, 1 imm
        logic [1:0] wb;      // 0 alu, 1 imm, 2 mem, 3 npc
        logic [1:0] npc;     // 0 npc, 1 jump reg, 2 pc+off, 3 branch
    } mux_sel_t;

    typedef struct packed {
        word_t       imm;
        mux_sel_t    sel;
        rd_rf_uop_t  rd_rf;
        ex_alu_uop_t ex_alu;
        ma_mem_uop_t ma_mem;
        wb_rf_uop_t  wb_rf;
        logic        fault;
    } decode_result_t;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        DONE
    } decode_state_t;

endpackage

// File: sources.f
hdl/rv_decode_pkg.sv
hdl/opcode_classify.sv
hdl/field_check.sv
hdl/imm_gen.sv
hdl/microcode_gen.sv
hdl/decode_ctrl.sv
hdl/instruction_decode.sv
tb/tb_instruction_decode.sv

// File: tb/tb_instruction_decode.sv
// Testbench for the RV32I instruction decoder
// Instruction table with expected results applied in a loop
// Compare tasks, busy pulse checks and a watchdog
`timescale 1ns/1ns

module tb_instruction_decode;
    import rv_decode_pkg::*;

    typedef struct packed {
        word_t          instr;
        decode_result_t exp;
    } entry_t;

    // Select order alu_a, alu_b, wb, npc
    localparam mux_sel_t SEL_LUI   = 6'b01_01_00;
    localparam mux_sel_t SEL_AUIPC = 6'b11_00_00;
    localparam mux_sel_t SEL_JAL   = 6'b01_11_10;
    localparam mux_sel_t SEL_JALR  = 6'b01_11_01;
    localparam mux_sel_t SEL_BR    = 6'b00_00_11;
    localparam mux_sel_t SEL_LD    = 6'b01_10_00;
    localparam mux_sel_t SEL_IMM   = 6'b01_00_00;  // Store, OP-IMM, invalid
    localparam mux_sel_t SEL_OP    = 6'b00_00_00;

    logic           clk = 1'b0;
    logic           reset;
    logic           available;
    word_t          instr;
    decode_result_t result;
    logic           busy;
    logic           fault;
    entry_t         table_q[$];
    int             fault_errs = 0;
    int             imm_errs = 0;
    int             result_errs = 0;
    int             proto_errs = 0;
    int             watchdog_cycles = 0;

    instruction_decode dut_i (.*);

    always #2 clk = ~clk;

    function automatic word_t store_instr(logic [11:0] i, reg_idx_t s2, reg_idx_t s1,
                                          logic [2:0] f3);
        return {i[11:5], s2, s1, f3, i[4:0], OPC_STORE};
    endfunction

    function automatic word_t branch_instr(logic [12:0] i, reg_idx_t s2, reg_idx_t s1,
                                           logic [2:0] f3);
        return {i[12], i[10:5], s2, s1, f3, i[4:1], i[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal_instr(logic [20:0] i, reg_idx_t rd);
        return {i[20], i[10:1], i[11], i[19:12], rd, OPC_JAL};
    endfunction

    // Stage microcode by opcode class with enables cleared on a fault
    function automatic decode_result_t expected_result(word_t w, logic flt, word_t imm,
                                                       mux_sel_t sel);
        logic [2:0]     f3;
        logic           op, opi, ld, st, br, lui, aui, jal;
        decode_result_t r;
        f3  = w[14:12];
        op  = w[6:0] == OPC_OP;
        opi = w[6:0] == OPC_OPIMM;
        ld  = w[6:0] == OPC_LOAD;
        st  = w[6:0] == OPC_STORE;
        br  = w[6:0] == OPC_BRANCH;
        lui = w[6:0] == OPC_LUI;
        aui = w[6:0] == OPC_AUIPC;
        jal = w[6:0] == OPC_JAL;
        r.imm    = imm;
        r.sel    = sel;
        r.fault  = flt;
        r.rd_rf  = {!flt && !(lui || aui || jal), w[18:15], w[23:20]};
        r.ex_alu = {!flt && !(lui || jal), br,
                    w[30] && ((op && (f3 == 0 || f3 == 5)) || (opi && f3 == 5)),
                    (op || opi || br) ? f3 : 3'd0};
        r.ma_mem = {!flt && (ld || st), st, f3};
        r.wb_rf  = {!flt && !(st || br), 1'b1, w[10:7], 4'd0};
        return r;
    endfunction

    task automatic add_entry(word_t w, logic flt, word_t imm, mux_sel_t sel);
        table_q.push_back({w, expected_result(w, flt, imm, sel)});
    endtask

    task automatic check_fault(logic got, logic exp, int idx);
        if (got !== exp) begin
            $display("** Error @ %0t ns: entry %0d fault %b, expected %b", $time, idx, got, exp);
            fault_errs++;
        end
    endtask

    task automatic check_imm(word_t got, word_t exp, int idx);
        if (got !== exp) begin
            $display("** Error @ %0t ns: entry %0d imm %h, expected %h", $time, idx, got, exp);
            imm_errs++;
        end
    endtask

    task automatic check_result(decode_result_t got, decode_result_t exp, int idx);
        if (got !== exp) begin
            $display("** Error @ %0t ns: entry %0d result %h, expected %h", $time, idx, got, exp);
            result_errs++;
        end
    endtask

    task automatic run_entry(int idx);
        entry_t         e;
        decode_result_t held;
        int             rise = 0;
        int             high = 0;
        e = table_q[idx];
        instr = e.instr;
        available = 1'b1;
        while (!busy && rise < 8) begin
            @(posedge clk);
            #1 rise++;
        end
        while (busy && high < 8) begin
            @(posedge clk);
            #1 high++;
        end
        if (rise != 1 || high != 1) begin
            $display("** Error @ %0t ns: entry %0d busy rose after %0d, high for %0d cycles",
                     $time, idx, rise, high);
            proto_errs++;
        end
        check_fault(fault, e.exp.fault, idx);
        check_imm(result.imm, e.exp.imm, idx);
        check_result(result, e.exp, idx);
        held = result;
        instr = ~e.instr;  // Request still up so the result must hold
        repeat (2) @(posedge clk);
        #1 check_result(result, held, idx);
        check_fault(fault, e.exp.fault, idx);
        available = 1'b0;
        repeat (2) @(posedge clk);
        #1 check_fault(fault, 1'b0, idx);
        if (busy !== 1'b0) begin
            $display("** Error @ %0t ns: entry %0d busy set while idle", $time, idx);
            proto_errs++;
        end
    endtask

    task automatic build_table();
        word_t      w;
        logic [2:0] f3;
        add_entry({20'hABCDE, 5'd5, OPC_LUI}, 1'b0, 32'hABCD_E000, SEL_LUI);
        add_entry({20'h80001, 5'd3, OPC_AUIPC}, 1'b0, 32'h8000_1000, SEL_AUIPC);
        add_entry(jal_instr(21'h1FFFFC, 5'd1), 1'b0, 32'hFFFF_FFFC, SEL_JAL);
        add_entry(jal_instr(21'h0ABCDE, 5'd15), 1'b0, 32'h000A_BCDE, SEL_JAL);
        add_entry({12'h00C, 5'd2, 3'd0, 5'd1, OPC_JALR}, 1'b0, 32'h0000_000C, SEL_JALR);
        add_entry(branch_instr(13'h1FF0, 5'd2, 5'd1, 3'd0), 1'b0, 32'hFFFF_FFF0, SEL_BR);
        add_entry(branch_instr(13'h0FFE, 5'd14, 5'd13, 3'd7), 1'b0, 32'h0000_0FFE, SEL_BR);
        add_entry(store_instr(12'hFFF, 5'd7, 5'd8, 3'd2), 1'b0, 32'hFFFF_FFFF, SEL_IMM);
        add_entry(store_instr(12'h7A5, 5'd9, 5'd10, 3'd0), 1'b0, 32'h0000_07A5, SEL_IMM);
        add_entry({12'h123, 5'd6, 3'd2, 5'd4, OPC_LOAD}, 1'b0, 32'h0000_0123, SEL_LD);
        add_entry({12'hFF8, 5'd11, 3'd4, 5'd12, OPC_LOAD}, 1'b0, 32'hFFFF_FFF8, SEL_LD);
        add_entry({12'hFFF, 5'd6, 3'd0, 5'd5, OPC_OPIMM}, 1'b0, 32'hFFFF_FFFF, SEL_IMM);
        add_entry({12'h403, 5'd8, 3'd5, 5'd7, OPC_OPIMM}, 1'b0, 32'h0000_0403, SEL_IMM);  // SRAI
        add_entry({7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP}, 1'b0, 32'h0000_0003, SEL_OP);
        add_entry({7'h20, 5'd6, 5'd5, 3'd0, 5'd4, OPC_OP}, 1'b0, 32'h0000_0406, SEL_OP);  // SUB
        add_entry({7'h20, 5'd9, 5'd8, 3'd5, 5'd7, OPC_OP}, 1'b0, 32'h0000_0409, SEL_OP);  // SRA
        for (int k = 0; k < 4; k++) begin
            w = {8'h00, 4'($urandom), 1'b0, 4'($urandom), 3'($urandom),
                 1'b0, 4'($urandom), OPC_OP};
            add_entry(w, 1'b0, {{20{w[31]}}, w[31:20]}, SEL_OP);
            f3 = 3'($urandom % 5);
            f3 = (f3 == 3'd3) ? 3'd5 : f3;
            w = {12'($urandom), 1'b0, 4'($urandom), f3, 1'b0, 4'($urandom), OPC_LOAD};
            add_entry(w, 1'b0, {{20{w[31]}}, w[31:20]}, SEL_LD);
        end
        add_entry(32'h0FF0_000F, 1'b1, 32'h0000_00FF, SEL_IMM);  // FENCE
        add_entry(32'h0000_0073, 1'b1, 32'h0000_0000, SEL_IMM);  // ECALL
        add_entry(32'h3002_9073, 1'b1, 32'h0000_0300, SEL_IMM);  // CSRRW
        add_entry({7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h3B}, 1'b1, 32'h0000_0002, SEL_IMM);
        for (int k = 0; k < 4; k++) begin
            w = $urandom;
            w[1:0] = 2'($urandom % 3);  // Standard opcodes all end in 11
            add_entry(w, 1'b1, {{20{w[31]}}, w[31:20]}, SEL_IMM);
        end
        add_entry({7'h00, 5'd2, 5'd1, 3'd0, 5'd17, OPC_OP}, 1'b1, 32'h0000_0002, SEL_OP);
        add_entry({12'h005, 5'd20, 3'd0, 5'd1, OPC_OPIMM}, 1'b1, 32'h0000_0005, SEL_IMM);
        add_entry(store_instr(12'h004, 5'd18, 5'd1, 3'd2), 1'b1, 32'h0000_0004, SEL_IMM);
        add_entry(store_instr(12'h010, 5'd2, 5'd3, 3'd3), 1'b1, 32'h0000_0010, SEL_IMM);
        add_entry({12'h020, 5'd1, 3'd3, 5'd2, OPC_LOAD}, 1'b1, 32'h0000_0020, SEL_LD);
        add_entry({12'h004, 5'd1, 3'd1, 5'd2, OPC_JALR}, 1'b1, 32'h0000_0004, SEL_JALR);
        add_entry(branch_instr(13'h0008, 5'd2, 5'd1, 3'd2), 1'b1, 32'h0000_0008, SEL_BR);
        add_entry({7'h01, 5'd2, 5'd3, 3'd0, 5'd1, OPC_OP}, 1'b1, 32'h0000_0022, SEL_OP);
        add_entry({7'h20, 5'd2, 5'd3, 3'd1, 5'd1, OPC_OP}, 1'b1, 32'h0000_0402, SEL_OP);
        add_entry({12'h405, 5'd3, 3'd1, 5'd1, OPC_OPIMM}, 1'b1, 32'h0000_0405, SEL_IMM);
        add_entry({12'h203, 5'd3, 3'd5, 5'd1, OPC_OPIMM}, 1'b1, 32'h0000_0203, SEL_IMM);
    endtask

    initial begin
        void'($urandom(25));
        reset = 1'b1;
        available = 1'b0;
        instr = '0;
        build_table();
        watchdog_cycles = table_q.size() * 10 + 100;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        repeat (2) @(posedge clk);
        #1 check_fault(fault, 1'b0, -1);
        if (busy !== 1'b0) begin
            $display("** Error @ %0t ns: busy set after reset", $time);
            proto_errs++;
        end
        foreach (table_q[i]) begin
            run_entry(i);
        end
        $display("Entries %0d, errors: fault %0d, imm %0d, result %0d, protocol %0d",
                 table_q.size(), fault_errs, imm_errs, result_errs, proto_errs);
        if (fault_errs + imm_errs + result_errs + proto_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: decoder run took more than %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule
